//--- mem_subsys_top.sv
`timescale 1ns/10ps
`default_nettype none

module mem_subsys_top
  import umi_pkg::*;
  import wb_pkg::*;
#(
  parameter int MEM_WORDS   = 4096,
  parameter int WAIT_STATES = 1
)
(
  input  wire             clk,
  input  wire             rst,
  input  wire umi_req_t   exec_req_i,     // execution unit data port
  output wire umi_rsp_t   exec_rsp_o,
  input  wire             flush_i,        // new fetch stream
  input  wire [ADR_W-1:0] flush_adr_i,
  output wire [7:0]       byte_o,         // instruction bytes out
  output wire             byte_valid_o,
  input  wire             byte_ready_i
);

  wire umi_req_t   fetch_req;   // prefetch queue to master
  wire umi_rsp_t   fetch_rsp;
  wire wb_req_t    wb_req;      // master to ram
  wire [DAT_W-1:0] wb_dat;
  wire             wb_ack;

  prefetch_queue u_pfq (
    .clk          (clk),
    .rst          (rst),
    .flush_i      (flush_i),
    .flush_adr_i  (flush_adr_i),
    .byte_o       (byte_o),
    .byte_valid_o (byte_valid_o),
    .byte_ready_i (byte_ready_i),
    .fetch_req_o  (fetch_req),
    .fetch_rsp_i  (fetch_rsp)
  );

  umi_wb_master u_master (
    .clk         (clk),
    .rst         (rst),
    .fetch_req_i (fetch_req),
    .fetch_rsp_o (fetch_rsp),
    .exec_req_i  (exec_req_i),
    .exec_rsp_o  (exec_rsp_o),
    .wb_req_o    (wb_req),
    .wb_dat_i    (wb_dat),
    .wb_ack_i    (wb_ack)
  );

  wb_ram #(
    .MEM_WORDS   (MEM_WORDS),
    .WAIT_STATES (WAIT_STATES)
  ) u_ram (
    .clk      (clk),
    .rst      (rst),
    .wb_req_i (wb_req),
    .wb_dat_o (wb_dat),
    .wb_ack_o (wb_ack)
  );

endmodule

`default_nettype wire

//--- prefetch_queue.sv
`timescale 1ns/10ps
`default_nettype none

module prefetch_queue
  import umi_pkg::*;
(
  input  wire             clk,
  input  wire             rst,
  input  wire             flush_i,       // restart stream at flush_adr_i
  input  wire [ADR_W-1:0] flush_adr_i,
  output logic [7:0]      byte_o,
  output logic            byte_valid_o,
  input  wire             byte_ready_i,
  output umi_req_t        fetch_req_o,
  input  wire umi_rsp_t   fetch_rsp_i
);

  logic [ADR_W-1:0] ptr;       // next address to fetch
  logic             run;       // set by the first flush
  logic [ADR_W-1:0] req_adr;   // address on the port
  logic             req_by;
  logic             req_stb;
  logic             stale;     // in-flight request is from before a flush
  logic [7:0]       q [4];     // byte queue, address order
  logic [1:0]       rd_ptr;
  logic [1:0]       wr_ptr;
  logic [2:0]       cnt;       // bytes held, 0 to 4
  logic [2:0]       need;      // bytes the next fetch brings
  logic [2:0]       n_push;
  logic             issue;
  logic             take;      // keep the returning data
  logic             pop;

  // odd pointer fetches one byte to get aligned again
  assign need = ptr[0] ? 3'd1 : 3'd2;

  // only issue when the answer is sure to fit
  assign issue = run && !req_stb && !flush_i && (cnt + need <= 3'd4);

  assign take   = req_stb && fetch_rsp_i.ack && !stale && !flush_i;
  assign n_push = take ? (req_by ? 3'd1 : 3'd2) : 3'd0;

  assign byte_valid_o = (cnt != 3'd0);
  assign byte_o       = q[rd_ptr];
  assign pop          = byte_valid_o & byte_ready_i;

  always_comb
  begin
    fetch_req_o.adr = req_adr;
    fetch_req_o.dat = '0;       // read only port
    fetch_req_o.we  = 1'b0;
    fetch_req_o.by  = req_by;
    fetch_req_o.stb = req_stb;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      run     <= 1'b0;
      req_stb <= 1'b0;
      stale   <= 1'b0;
    end
    else
    begin
      if (flush_i)
        run <= 1'b1;
      if (req_stb && fetch_rsp_i.ack)
      begin
        req_stb <= 1'b0;   // one idle cycle before the next fetch
        stale   <= 1'b0;
      end
      else if (issue)
        req_stb <= 1'b1;
      // cannot pull back a request, let it finish and drop it
      if (flush_i && req_stb && !fetch_rsp_i.ack)
        stale <= 1'b1;
    end
  end

  // fetch pointer and request payload
  always_ff @(posedge clk)
  begin
    if (flush_i)
      ptr <= flush_adr_i;
    else if (issue)
      ptr <= ptr + ADR_W'(need);
    if (issue)
    begin
      req_adr <= ptr;
      req_by  <= ptr[0];
    end
  end

  // word reads return the lower address in the low byte
  always_ff @(posedge clk)
  begin
    if (take)
    begin
      q[wr_ptr] <= fetch_rsp_i.dat[7:0];
      if (!req_by)
        q[wr_ptr + 2'd1] <= fetch_rsp_i.dat[15:8];
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst || flush_i)
    begin
      rd_ptr <= 2'd0;
      wr_ptr <= 2'd0;
      cnt    <= 3'd0;   // flush empties the queue
    end
    else
    begin
      if (pop)
        rd_ptr <= rd_ptr + 2'd1;
      wr_ptr <= wr_ptr + n_push[1:0];
      cnt    <= cnt + n_push - {2'b00, pop};
    end
  end

endmodule

`default_nettype wire

//--- project.f
umi_pkg.sv
wb_pkg.sv
umi_wb_master.sv
prefetch_queue.sv
wb_ram.sv
mem_subsys_top.sv
tb_mem_subsys.sv

//--- tb_mem_subsys.sv
`timescale 1ns/10ps
`default_nettype none

module tb_mem_subsys
  import umi_pkg::*;
();

  localparam int MEM_WORDS   = 4096;
  localparam int WAIT_STATES = 1;
  localparam int MODEL_BYTES = 2 * MEM_WORDS;

  logic             clk;
  logic             rst;
  umi_req_t         exec_req;      // exec port, driven on falling edges
  umi_rsp_t         exec_rsp;
  logic             flush;
  logic [ADR_W-1:0] flush_adr;
  logic [7:0]       byte_out;
  logic             byte_valid;
  logic             byte_ready;

  logic [7:0]  model [MODEL_BYTES];   // expected ram contents, byte wide
  logic [31:0] lfsr;
  int          checks;
  int          errors;
  int          test_err;              // error count when a test started

  mem_subsys_top #(
    .MEM_WORDS   (MEM_WORDS),
    .WAIT_STATES (WAIT_STATES)
  ) UUT (
    .clk          (clk),
    .rst          (rst),
    .exec_req_i   (exec_req),
    .exec_rsp_o   (exec_rsp),
    .flush_i      (flush),
    .flush_adr_i  (flush_adr),
    .byte_o       (byte_out),
    .byte_valid_o (byte_valid),
    .byte_ready_i (byte_ready)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;   // 20 ns period
  end

  // fibonacci lfsr, taps 32 22 2 1
  // one step per bit handed out
  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[14:0], fb};
    end
    return r;
  endfunction

  function automatic logic [15:0] sext8(input logic [7:0] b);
    return {{8{b[7]}}, b};
  endfunction

  // bytes sign extended, words are low byte at adr, high byte at adr+1
  function automatic logic [15:0] expect_read(input int adr, input logic by);
    if (by)
      return sext8(model[adr]);
    else
      return {model[adr + 1], model[adr]};
  endfunction

  task automatic check(input string name, input logic [15:0] got, input logic [15:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("mismatch %s: got %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic abort_on_timeout(input string what);
    $display("timeout waiting for %s at %0t", what, $time);
    $display("Simulation FAILED");
    $finish;
  endtask

  task automatic report_test(input int num, input string name);
    $display("test %0d %s: %0d errors", num, name, errors - test_err);
  endtask

  // one exec access, starts and ends on a falling edge
  task automatic exec_access(input int adr, input logic [15:0] dat, input logic we,
                             input logic by, output logic [15:0] rdat);
    int wait_cnt;
    exec_req.adr = adr[ADR_W-1:0];
    exec_req.dat = dat;
    exec_req.we  = we;
    exec_req.by  = by;
    exec_req.stb = 1'b1;   // held until ack
    wait_cnt     = 0;
    do
    begin
      @(negedge clk);
      wait_cnt++;
      if (wait_cnt > 200)
        abort_on_timeout("exec ack");
    end while (!exec_rsp.ack);
    rdat         = exec_rsp.dat;   // valid with ack
    exec_req.stb = 1'b0;
    exec_req.we  = 1'b0;
  endtask

  task automatic exec_write(input int adr, input logic [15:0] dat, input logic by);
    logic [15:0] ignored;
    exec_access(adr, dat, 1'b1, by, ignored);
    model[adr] = dat[7:0];        // byte writes take the low byte
    if (!by)
      model[adr + 1] = dat[15:8];
  endtask

  task automatic exec_read_check(input int adr, input logic by);
    logic [15:0] rdat;
    exec_access(adr, 16'h0000, 1'b0, by, rdat);
    check($sformatf("exec_rsp_o.dat @%h", adr), rdat, expect_read(adr, by));
  endtask

  // one cycle flush pulse, ready held low so nothing is popped meanwhile
  task automatic flush_to(input int adr);
    byte_ready = 1'b0;
    flush      = 1'b1;
    flush_adr  = adr[ADR_W-1:0];
    @(negedge clk);
    flush      = 1'b0;
  endtask

  // take count bytes from the queue and compare in address order
  task automatic stream_check(input int start, input int count, input bit throttle);
    int          got;
    int          cycles;
    logic [15:0] r;
    got    = 0;
    cycles = 0;
    while (got < count)
    begin
      if (throttle)
      begin
        r          = rand_bits(1);
        byte_ready = r[0];   // random back-pressure
      end
      else
        byte_ready = 1'b1;
      if (byte_valid && byte_ready)   // pops on the coming rising edge
      begin
        check($sformatf("byte_o @%h", start + got), {8'h00, byte_out},
              {8'h00, model[start + got]});
        got++;
      end
      @(negedge clk);
      cycles++;
      if (cycles > 50 * count + 100)
        abort_on_timeout("prefetch bytes");
    end
    byte_ready = 1'b0;
  endtask

  task automatic test_aligned_words();
    test_err = errors;
    for (int i = 0; i < 10; i++)   // idle after reset, nothing may pulse
    begin
      check("exec_rsp_o.ack", {15'h0000, exec_rsp.ack}, 16'h0000);
      check("byte_valid_o", {15'h0000, byte_valid}, 16'h0000);
      @(negedge clk);
    end
    for (int a = 0; a < 256; a += 2)   // fills the area later tests use
      exec_write(a, rand_bits(16), 1'b0);
    for (int a = 0; a < 256; a += 2)
      exec_read_check(a, 1'b0);
    report_test(1, "reset and aligned words");
  endtask

  task automatic test_odd_words();
    int a;
    test_err = errors;
    for (int i = 0; i < 16; i++)
    begin
      a = 'h41 + 6 * i;   // always odd, split on the bus
      exec_write(a, rand_bits(16), 1'b0);
      exec_read_check(a, 1'b0);
      exec_read_check(a - 1, 1'b1);   // neighbours untouched
      exec_read_check(a + 2, 1'b1);
    end
    report_test(2, "odd address words");
  endtask

  task automatic test_bytes();
    int a;
    test_err = errors;
    for (int i = 0; i < 16; i++)
      exec_read_check(rand_bits(8), 1'b1);
    for (int i = 0; i < 16; i++)
    begin
      a = rand_bits(8);
      exec_write(a, rand_bits(16), 1'b1);   // high byte is junk
      exec_read_check(a & ~1, 1'b0);        // whole word, other byte unchanged
    end
    report_test(3, "byte reads and writes");
  endtask

  task automatic test_prefetch();
    test_err = errors;
    flush_to('h23);   // odd start, byte fetch first
    stream_check('h23, 24, 1'b1);
    flush_to('h60);
    stream_check('h60, 24, 1'b1);
    report_test(4, "prefetch stream");
  endtask

  task automatic test_concurrent();
    int          cadr [8];
    logic [15:0] cdat [8];
    // exec stimulus drawn up front, lfsr stays with the stream
    for (int i = 0; i < 8; i++)
    begin
      cadr[i] = 'h80 + rand_bits(6);   // away from the streamed bytes
      cdat[i] = rand_bits(16);
    end
    test_err = errors;
    flush_to('h05);
    fork
      stream_check('h05, 40, 1'b1);
      begin
        for (int i = 0; i < 8; i++)
        begin
          exec_write(cadr[i], cdat[i], i[0]);   // byte and word in turn
          exec_read_check(cadr[i], 1'b0);
          exec_read_check(cadr[i] + 1, 1'b1);
        end
      end
    join
    report_test(5, "exec and prefetch together");
  endtask

  task automatic test_flush_mid();
    int a;
    test_err = errors;
    flush_to('h31);
    stream_check('h31, 6, 1'b0);   // full speed, ready held high
    for (int i = 0; i < 6; i++)
    begin
      a = rand_bits(7);   // stream stays inside the filled bytes
      flush_to(a);   // old bytes still queued, maybe a fetch in flight
      stream_check(a, 1 + rand_bits(3), 1'b1);
    end
    report_test(6, "flush mid stream");
  endtask

  initial
  begin
    rst        = 1'b1;
    exec_req   = '0;
    flush      = 1'b0;
    flush_adr  = '0;
    byte_ready = 1'b0;
    lfsr       = 32'hb4976f46;
    checks     = 0;
    errors     = 0;
    test_err   = 0;
    repeat (8) @(negedge clk);
    rst = 1'b0;
    test_aligned_words();
    test_odd_words();
    test_bytes();
    test_prefetch();
    test_concurrent();
    test_flush_mid();
    $display("done: %0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- umi_pkg.sv
`default_nettype none

// processor side of the memory subsystem
// 16-bit data, byte addressed, 1 MB space
package umi_pkg;

  localparam int ADR_W = 20;   // byte address bits
  localparam int DAT_W = 16;   // data bus bits

  // request from a cpu-side port
  // everything but stb is held stable until ack
  typedef struct packed {
    logic [ADR_W-1:0] adr;     // byte address
    logic [DAT_W-1:0] dat;     // write data, byte writes use the low byte
    logic             we;      // write when set
    logic             by;      // byte access when set, word otherwise
    logic             stb;     // request strobe
  } umi_req_t;

  // response back to the port
  typedef struct packed {
    logic [DAT_W-1:0] dat;     // read data, bytes come sign extended
    logic             ack;     // one cycle done pulse
  } umi_rsp_t;

endpackage

`default_nettype wire

//--- umi_wb_master.sv
`timescale 1ns/10ps
`default_nettype none

module umi_wb_master
  import umi_pkg::*;
  import wb_pkg::*;
(
  input  wire             clk,
  input  wire             rst,
  input  wire umi_req_t   fetch_req_i,   // prefetch side, never writes
  output umi_rsp_t        fetch_rsp_o,
  input  wire umi_req_t   exec_req_i,    // execution unit data port
  output umi_rsp_t        exec_rsp_o,
  output wb_req_t         wb_req_o,
  input  wire [DAT_W-1:0] wb_dat_i,
  input  wire             wb_ack_i
);

  typedef enum logic [2:0] {
    IDLE = 3'd0,
    BY1E = 3'd1,   // exec, first bus cycle
    BY2E = 3'd2,   // exec, second half of a split word
    ACKE = 3'd3,   // exec ack going out
    BY1F = 3'd4,   // fetch, first bus cycle
    BY2F = 3'd5,   // fetch, second half
    ACKF = 3'd6    // fetch ack going out
  } state_t;

  state_t cs;
  state_t ns;

  logic             split_e;    // exec word at odd address
  logic             split_f;    // same for fetch
  logic             n_exec;     // next state belongs to exec
  logic             n_busy;     // next state drives the bus
  logic             n_second;   // next state is a second bus cycle
  umi_req_t         nreq;       // request the bus is loaded from
  logic             c_exec;     // exec bus cycle running now
  logic             c_fetch;
  logic             c_second;
  umi_req_t         creq;       // request that completes now
  logic [DAT_W-1:0] blw;        // low lane, sign extended
  logic [DAT_W-1:0] bhw;        // high lane, sign extended
  logic [DAT_W-1:0] rd_first;   // read result after the first bus cycle

  assign split_e = exec_req_i.adr[0] & ~exec_req_i.by;
  assign split_f = fetch_req_i.adr[0] & ~fetch_req_i.by;

  assign n_exec   = (ns == BY1E) || (ns == BY2E);
  assign n_busy   = n_exec || (ns == BY1F) || (ns == BY2F);
  assign n_second = (ns == BY2E) || (ns == BY2F);
  assign nreq     = n_exec ? exec_req_i : fetch_req_i;

  assign c_exec   = (cs == BY1E) || (cs == BY2E);
  assign c_fetch  = (cs == BY1F) || (cs == BY2F);
  assign c_second = (cs == BY2E) || (cs == BY2F);
  assign creq     = c_exec ? exec_req_i : fetch_req_i;

  assign blw = {{8{wb_dat_i[7]}}, wb_dat_i[7:0]};
  assign bhw = {{8{wb_dat_i[15]}}, wb_dat_i[15:8]};

  // odd address reads the high lane, its byte lands low
  assign rd_first = creq.adr[0] ? bhw : (creq.by ? blw : wb_dat_i);

  always_ff @(posedge clk)
  begin
    if (rst)
      cs <= IDLE;
    else
      cs <= ns;
  end

  // arbitration, exec wins from idle
  // after each access the other port goes next if it waits
  always_comb
  begin
    ns = cs;
    case (cs)
      BY1E:
        if (wb_ack_i)
        begin
          if (split_e)
            ns = BY2E;
          else if (fetch_req_i.stb && !fetch_rsp_o.ack)
            ns = BY1F;
          else
            ns = ACKE;
        end
      BY2E:
        if (wb_ack_i)
          ns = fetch_req_i.stb ? BY1F : ACKE;
      ACKE:
        ns = fetch_req_i.stb ? BY1F : IDLE;   // exec stb still old here
      BY1F:
        if (wb_ack_i)
        begin
          if (split_f)
            ns = BY2F;
          else if (exec_req_i.stb && !exec_rsp_o.ack)
            ns = BY1E;
          else
            ns = ACKF;
        end
      BY2F:
        if (wb_ack_i)
          ns = exec_req_i.stb ? BY1E : ACKF;
      ACKF:
        ns = exec_req_i.stb ? BY1E : IDLE;
      default:   // idle
        if (exec_req_i.stb)
          ns = BY1E;
        else if (fetch_req_i.stb)
          ns = BY1F;
        else
          ns = IDLE;
    endcase
  end

  // bus outputs registered from the next state
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wb_req_o.cyc <= 1'b0;
      wb_req_o.stb <= 1'b0;
      wb_req_o.we  <= 1'b0;
    end
    else
    begin
      wb_req_o.cyc <= n_busy;
      wb_req_o.stb <= n_busy;
      wb_req_o.we  <= n_busy & nreq.we;
    end
    if (n_busy)
    begin
      // second half always goes to the next word, low lane
      wb_req_o.adr <= n_second ? nreq.adr[ADR_W-1:1] + 1'b1 : nreq.adr[ADR_W-1:1];
      if (n_second)
        wb_req_o.sel <= 2'b01;
      else if (nreq.adr[0])
        wb_req_o.sel <= 2'b10;
      else
        wb_req_o.sel <= nreq.by ? 2'b01 : 2'b11;
      // odd address, low data byte rides the high lane
      wb_req_o.dat <= nreq.adr[0] ? {nreq.dat[7:0], nreq.dat[15:8]} : nreq.dat;
    end
  end

  // port acks on the last bus ack, read data alongside
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      exec_rsp_o.ack  <= 1'b0;
      fetch_rsp_o.ack <= 1'b0;
    end
    else
    begin
      exec_rsp_o.ack  <= wb_ack_i && ((cs == BY1E && !split_e) || cs == BY2E);
      fetch_rsp_o.ack <= wb_ack_i && ((cs == BY1F && !split_f) || cs == BY2F);
    end
    if (wb_ack_i && c_exec)
      exec_rsp_o.dat <= c_second ? {wb_dat_i[7:0], exec_rsp_o.dat[7:0]} : rd_first;
    if (wb_ack_i && c_fetch)
      fetch_rsp_o.dat <= c_second ? {wb_dat_i[7:0], fetch_rsp_o.dat[7:0]} : rd_first;
  end

endmodule

`default_nettype wire

//--- wb_pkg.sv
`default_nettype none

// wishbone side of the memory subsystem
package wb_pkg;

  import umi_pkg::*;

  localparam int SEL_W = DAT_W / 8;   // one select per byte lane

  // master to slave, data and ack come back as plain wires
  typedef struct packed {
    logic [ADR_W-1:1] adr;     // word address
    logic [DAT_W-1:0] dat;     // write data, already lane steered
    logic             we;
    logic [SEL_W-1:0] sel;     // byte lane enables
    logic             stb;
    logic             cyc;     // high together with stb
  } wb_req_t;

endpackage

`default_nettype wire

//--- wb_ram.sv
`timescale 1ns/10ps
`default_nettype none

module wb_ram
  import umi_pkg::*;
  import wb_pkg::*;
#(
  parameter int MEM_WORDS   = 4096,   // 16-bit words
  parameter int WAIT_STATES = 1       // extra cycles before ack
)
(
  input  wire              clk,
  input  wire              rst,
  input  wire wb_req_t     wb_req_i,
  output logic [DAT_W-1:0] wb_dat_o,
  output logic             wb_ack_o
);

  localparam int IDX_W = $clog2(MEM_WORDS);
  localparam int CNT_W = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

  logic [DAT_W-1:0] mem [MEM_WORDS];
  logic [IDX_W-1:0] idx;         // word index, upper address bits ignored
  logic [CNT_W-1:0] cnt;         // wait cycles so far
  logic             go;          // access waiting for ack
  logic             last;        // ack goes out next edge

  assign idx  = wb_req_i.adr[IDX_W:1];
  assign go   = wb_req_i.cyc & wb_req_i.stb & ~wb_ack_o;
  assign last = go && (cnt == CNT_W'(WAIT_STATES));

  // counter restarts after every ack, so a held stb counts again
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      cnt      <= '0;
      wb_ack_o <= 1'b0;
    end
    else
    begin
      wb_ack_o <= last;
      if (go && !last)
        cnt <= cnt + 1'b1;
      else
        cnt <= '0;
    end
  end

  // write on the ack edge, read data lines up with ack
  always_ff @(posedge clk)
  begin
    if (last && wb_req_i.we)
      for (int i = 0; i < SEL_W; i++)
        if (wb_req_i.sel[i])
          mem[idx][i*8 +: 8] <= wb_req_i.dat[i*8 +: 8];
    if (last)
      wb_dat_o <= mem[idx];
  end

endmodule

`default_nettype wire
